// ==== elink_macros.svh ====
`ifndef ELINK_MACROS_SVH
`define ELINK_MACROS_SVH

`define ELINK_AW            32          // Address width
`define ELINK_DW            32          // Data width
`define ELINK_PW            104         // Packet width
`define ELINK_BYTES         13          // Bytes per packet on the lane

`define ELINK_TX_DEPTH      4           // Tx slots, also initial host credits
`define ELINK_RX_DEPTH      4           // Rx slots, also initial link credits
`define ELINK_HOST_CREDITS  2           // Rx credits toward host after reset

`define ELINK_CHIPID        12'h810     // Board chip ID
`define ELINK_MAILBOX_OFS   20'hF0320   // Mailbox low address

`define NGPIO               24          // GPIO pad count

`endif

// ==== elink_pkg.sv ====
`include "elink_macros.svh"

package elink_pkg;

   // Transfer size of a packet
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,               // 8-bit
      DM_HALF   = 2'b01,               // 16-bit
      DM_WORD   = 2'b10,               // 32-bit
      DM_DOUBLE = 2'b11                // 64-bit write
   } datamode_e;

   // Upper word, decoded by write/datamode
   typedef union packed {
      logic [`ELINK_AW-1:0] srcaddr;   // Return address for reads
      logic [`ELINK_DW-1:0] data_hi;   // High data of double writes
   } pkt_upper_u;

   // One link packet, MSB goes out first
   typedef struct packed {
      logic                 write;     // Write when set
      datamode_e            datamode;  // Transfer size
      logic [4:0]           ctrlmode;  // Control bits
      logic [`ELINK_AW-1:0] dstaddr;   // Chip ID in top 12 bits
      logic [`ELINK_DW-1:0] data;      // Low data
      pkt_upper_u           upper;     // Srcaddr or data_hi
   } packet_t;

endpackage

// ==== elink_tx.sv ====
`timescale 1ns/1ns
`include "elink_macros.svh"

module elink_tx (
   input  logic               sys_clk_i,
   input  logic               rst_i,
   input  logic               tx_valid_i,    // Host push
   input  elink_pkg::packet_t tx_packet_i,
   output logic               tx_credit_o,   // Slot freed, back to host
   input  logic               txi_credit_i,  // Link credit from receiver
   output logic [7:0]         txo_data_o,
   output logic               txo_frame_o,
   output logic               tx_busy_o
);

   localparam int PTRW = $clog2(`ELINK_TX_DEPTH);
   localparam int CNTW = $clog2(`ELINK_TX_DEPTH + 1);
   localparam int LCW  = $clog2(`ELINK_RX_DEPTH + 1);

   elink_pkg::packet_t      buf_mem [`ELINK_TX_DEPTH];  // Packet slots
   logic [PTRW-1:0]         wr_ptr;
   logic [PTRW-1:0]         rd_ptr;
   logic [CNTW-1:0]         buf_cnt;                    // Occupied slots
   logic [LCW-1:0]          link_cred;                  // Remote rx slots owned
   logic [`ELINK_PW-1:0]    shift_q;                    // Outgoing packet
   logic [`ELINK_BYTES-1:0] byte_idx;                   // One-hot byte position
   logic                    ser_idle;
   logic                    load;

   assign ser_idle = (byte_idx == '0);                  // Gap or idle
   assign load     = ser_idle && (buf_cnt != '0) && (link_cred != '0);

   assign txo_data_o  = shift_q[`ELINK_PW-1 -: 8];      // MS byte first
   assign txo_frame_o = ~ser_idle;
   assign tx_busy_o   = (buf_cnt != '0) | ~ser_idle;

   always_ff @(posedge sys_clk_i) begin
      if (tx_valid_i) begin
         buf_mem[wr_ptr] <= tx_packet_i;                // Host only pushes with credit
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         buf_cnt <= '0;
      end else begin
         if (tx_valid_i) begin
            wr_ptr <= wr_ptr + 1'b1;                    // Depth is a power of two
         end
         if (load) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({tx_valid_i, load})
            2'b10:   buf_cnt <= buf_cnt + 1'b1;
            2'b01:   buf_cnt <= buf_cnt - 1'b1;
            default: buf_cnt <= buf_cnt;                // Both or neither
         endcase
      end
   end

   // Link credits: spent per packet, returned by the far receiver
   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         link_cred <= LCW'(`ELINK_RX_DEPTH);
      end else begin
         case ({load, txi_credit_i})
            2'b10:   link_cred <= link_cred - 1'b1;
            2'b01:   link_cred <= link_cred + 1'b1;
            default: link_cred <= link_cred;
         endcase
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         byte_idx    <= '0;
         tx_credit_o <= 1'b0;
      end else begin
         tx_credit_o <= load;                           // Lines up with first byte
         if (load) begin
            byte_idx <= `ELINK_BYTES'(1);
         end else begin
            byte_idx <= byte_idx << 1;                  // Falls to zero after last byte
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (load) begin
         shift_q <= buf_mem[rd_ptr];
      end else if (txo_frame_o) begin
         shift_q <= {shift_q[`ELINK_PW-9:0], 8'h00};    // Next byte up
      end
   end

endmodule

// ==== elink_rx.sv ====
`timescale 1ns/1ns
`include "elink_macros.svh"

module elink_rx (
   input  logic               sys_clk_i,
   input  logic               rst_i,
   input  logic [7:0]         rxi_data_i,
   input  logic               rxi_frame_i,
   output logic               rxo_credit_o,    // Slot freed, back to sender
   output logic               rx_valid_o,
   output elink_pkg::packet_t rx_packet_o,
   input  logic               rx_credit_i,     // Host returns a credit
   input  logic [11:0]        chipid_i,
   input  logic               mailbox_clr_i,
   output logic [63:0]        mailbox_data_o,
   output logic               mailbox_irq_o,
   output logic               rx_busy_o
);

   localparam int PTRW = $clog2(`ELINK_RX_DEPTH);
   localparam int CNTW = $clog2(`ELINK_RX_DEPTH + 1);
   localparam int HCW  = $clog2(`ELINK_HOST_CREDITS + 1);
   localparam int BCW  = $clog2(`ELINK_BYTES);

   elink_pkg::packet_t     buf_mem [`ELINK_RX_DEPTH];
   elink_pkg::packet_t     pkt_in;                  // Packet with its last byte
   logic [`ELINK_PW-9:0]   in_sr;                   // First 12 bytes
   logic [BCW-1:0]         byte_cnt;
   logic [PTRW-1:0]        wr_ptr;
   logic [PTRW-1:0]        rd_ptr;
   logic [CNTW-1:0]        buf_cnt;
   logic [HCW-1:0]         host_cred;
   logic [1:0]             cred_pend;               // Credits not yet sent back
   logic [2:0]             cred_sum;
   logic                   pkt_done;
   logic                   is_mbx;
   logic                   push;
   logic                   pop;

   assign pkt_in   = {in_sr, rxi_data_i};
   assign pkt_done = rxi_frame_i && (byte_cnt == BCW'(`ELINK_BYTES - 1));
   assign is_mbx   = pkt_in.write
                     && (pkt_in.dstaddr[`ELINK_AW-1 -: 12] == chipid_i)
                     && (pkt_in.dstaddr[19:0] == `ELINK_MAILBOX_OFS);
   assign push     = pkt_done && !is_mbx;
   assign pop      = (buf_cnt != '0) && (host_cred != '0);   // Held while no credit
   assign cred_sum = 3'(cred_pend) + 3'(pop) + 3'(pkt_done && is_mbx);

   assign rx_busy_o = (buf_cnt != '0) | (byte_cnt != '0) | rxi_frame_i;

   // Deserializer
   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         byte_cnt <= '0;
      end else if (!rxi_frame_i || pkt_done) begin
         byte_cnt <= '0;                            // Resync on frame low
      end else begin
         byte_cnt <= byte_cnt + 1'b1;
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (rxi_frame_i) begin
         in_sr <= {in_sr[`ELINK_PW-17:0], rxi_data_i};
      end
   end

   // Receive buffer
   always_ff @(posedge sys_clk_i) begin
      if (push) begin
         buf_mem[wr_ptr] <= pkt_in;
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         buf_cnt <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   buf_cnt <= buf_cnt + 1'b1;
            2'b01:   buf_cnt <= buf_cnt - 1'b1;
            default: buf_cnt <= buf_cnt;
         endcase
      end
   end

   // Host delivery and host credit counter
   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         rx_valid_o <= 1'b0;
         host_cred  <= HCW'(`ELINK_HOST_CREDITS);
      end else begin
         rx_valid_o <= pop;
         case ({pop, rx_credit_i})
            2'b10:   host_cred <= host_cred - 1'b1;
            2'b01:   host_cred <= host_cred + 1'b1;
            default: host_cred <= host_cred;
         endcase
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (pop) begin
         rx_packet_o <= buf_mem[rd_ptr];
      end
   end

   // Link credit return, one pulse per freed slot
   // A delivery and a mailbox hit can land in one cycle, so one may wait
   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         rxo_credit_o <= 1'b0;
         cred_pend    <= '0;
      end else if (cred_sum != '0) begin
         rxo_credit_o <= 1'b1;
         cred_pend    <= 2'(cred_sum - 3'd1);
      end else begin
         rxo_credit_o <= 1'b0;
         cred_pend    <= '0;
      end
   end

   // Mailbox
   always_ff @(posedge sys_clk_i) begin
      if (pkt_done && is_mbx) begin
         mailbox_data_o[31:0] <= pkt_in.data;
         if (pkt_in.datamode == elink_pkg::DM_DOUBLE) begin
            mailbox_data_o[63:32] <= pkt_in.upper.data_hi;
         end else begin
            mailbox_data_o[63:32] <= '0;            // No high half below 64 bits
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         mailbox_irq_o <= 1'b0;
      end else if (pkt_done && is_mbx) begin
         mailbox_irq_o <= 1'b1;                     // New message beats clear
      end else if (mailbox_clr_i) begin
         mailbox_irq_o <= 1'b0;
      end
   end

endmodule

// ==== elink.sv ====
`timescale 1ns/1ns
`include "elink_macros.svh"

module elink (
   input  logic               sys_clk_i,
   input  logic               rst_i,
   input  logic               tx_valid_i,
   input  elink_pkg::packet_t tx_packet_i,
   output logic               tx_credit_o,
   input  logic               txi_credit_i,
   output logic [7:0]         txo_data_o,
   output logic               txo_frame_o,
   input  logic [7:0]         rxi_data_i,
   input  logic               rxi_frame_i,
   output logic               rxo_credit_o,
   output logic               rx_valid_o,
   output elink_pkg::packet_t rx_packet_o,
   input  logic               rx_credit_i,
   input  logic               mailbox_clr_i,
   output logic [63:0]        mailbox_data_o,
   output logic               mailbox_irq_o,
   output logic [11:0]        chipid_o,
   output logic               elink_active_o
);

   logic [11:0] chipid;
   logic        tx_busy;
   logic        rx_busy;

   assign chipid   = `ELINK_CHIPID;                 // Fixed board ID
   assign chipid_o = chipid;

   elink_tx u_elink_tx (
      .sys_clk_i    (sys_clk_i),
      .rst_i        (rst_i),
      .tx_valid_i   (tx_valid_i),
      .tx_packet_i  (tx_packet_i),
      .tx_credit_o  (tx_credit_o),
      .txi_credit_i (txi_credit_i),
      .txo_data_o   (txo_data_o),
      .txo_frame_o  (txo_frame_o),
      .tx_busy_o    (tx_busy)
   );

   elink_rx u_elink_rx (
      .sys_clk_i      (sys_clk_i),
      .rst_i          (rst_i),
      .rxi_data_i     (rxi_data_i),
      .rxi_frame_i    (rxi_frame_i),
      .rxo_credit_o   (rxo_credit_o),
      .rx_valid_o     (rx_valid_o),
      .rx_packet_o    (rx_packet_o),
      .rx_credit_i    (rx_credit_i),
      .chipid_i       (chipid),
      .mailbox_clr_i  (mailbox_clr_i),
      .mailbox_data_o (mailbox_data_o),
      .mailbox_irq_o  (mailbox_irq_o),
      .rx_busy_o      (rx_busy)
   );

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         elink_active_o <= 1'b0;
      end else begin
         elink_active_o <= tx_busy | rx_busy;      // Board activity LED
      end
   end

endmodule

// ==== pio_pads.sv ====
`timescale 1ns/1ns
`include "elink_macros.svh"

module pio_pads (
   input  logic              sys_clk_i,
   input  logic              rst_i,
   input  logic [`NGPIO-1:0] ps_gpio_o_i,
   input  logic [`NGPIO-1:0] ps_gpio_t_i,     // 1 floats the pad
   output logic [`NGPIO-1:0] ps_gpio_i_o,
   inout  wire  [`NGPIO-1:0] gpio_io,
   input  logic              i2c_scl_o_i,
   input  logic              i2c_scl_t_i,
   input  logic              i2c_sda_o_i,
   input  logic              i2c_sda_t_i,
   output logic              i2c_scl_i_o,
   output logic              i2c_sda_i_o,
   inout  wire               i2c_scl_io,
   inout  wire               i2c_sda_io
);

   typedef struct packed {
      logic              scl;
      logic              sda;
      logic [`NGPIO-1:0] gpio;
   } pad_in_t;

   pad_in_t pad_raw;                          // Straight from the pins
   pad_in_t pad_meta;                         // First sync stage
   pad_in_t pad_sync;                         // Second sync stage

   // Tristate drivers, one per GPIO pin
   for (genvar i = 0; i < `NGPIO; i++) begin : g_gpio
      assign gpio_io[i] = ps_gpio_t_i[i] ? 1'bz : ps_gpio_o_i[i];
   end

   // Open drain, only ever pulls low
   assign i2c_scl_io = (!i2c_scl_t_i && !i2c_scl_o_i) ? 1'b0 : 1'bz;
   assign i2c_sda_io = (!i2c_sda_t_i && !i2c_sda_o_i) ? 1'b0 : 1'bz;

   assign pad_raw.scl  = i2c_scl_io;
   assign pad_raw.sda  = i2c_sda_io;
   assign pad_raw.gpio = gpio_io;

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         pad_meta <= '0;
         pad_sync <= '0;
      end else begin
         pad_meta <= pad_raw;                 // Async pins
         pad_sync <= pad_meta;
      end
   end

   assign ps_gpio_i_o = pad_sync.gpio;        // Two cycles from pin
   assign i2c_scl_i_o = pad_sync.scl;
   assign i2c_sda_i_o = pad_sync.sda;

endmodule

// ==== parallella_base.sv ====
`timescale 1ns/1ns
`include "elink_macros.svh"

module parallella_base (
   input  logic               sys_clk_i,
   input  logic               rst_i,
   input  logic               tx_valid_i,
   input  elink_pkg::packet_t tx_packet_i,
   output logic               tx_credit_o,
   input  logic               txi_credit_i,
   output logic [7:0]         txo_data_o,
   output logic               txo_frame_o,
   input  logic [7:0]         rxi_data_i,
   input  logic               rxi_frame_i,
   output logic               rxo_credit_o,
   output logic               rx_valid_o,
   output elink_pkg::packet_t rx_packet_o,
   input  logic               rx_credit_i,
   input  logic               mailbox_clr_i,
   output logic [63:0]        mailbox_data_o,
   output logic               mailbox_irq_o,
   output logic [11:0]        chipid_o,
   output logic               elink_active_o,
   input  logic [`NGPIO-1:0]  ps_gpio_o_i,
   input  logic [`NGPIO-1:0]  ps_gpio_t_i,
   output logic [`NGPIO-1:0]  ps_gpio_i_o,
   inout  wire  [`NGPIO-1:0]  gpio_io,
   input  logic               i2c_scl_o_i,
   input  logic               i2c_scl_t_i,
   input  logic               i2c_sda_o_i,
   input  logic               i2c_sda_t_i,
   output logic               i2c_scl_i_o,
   output logic               i2c_sda_i_o,
   inout  wire                i2c_scl_io,
   inout  wire                i2c_sda_io,
   output logic               chip_nreset_o     // Epiphany reset, active low
);

   elink u_elink (
      .sys_clk_i      (sys_clk_i),
      .rst_i          (rst_i),
      .tx_valid_i     (tx_valid_i),
      .tx_packet_i    (tx_packet_i),
      .tx_credit_o    (tx_credit_o),
      .txi_credit_i   (txi_credit_i),
      .txo_data_o     (txo_data_o),
      .txo_frame_o    (txo_frame_o),
      .rxi_data_i     (rxi_data_i),
      .rxi_frame_i    (rxi_frame_i),
      .rxo_credit_o   (rxo_credit_o),
      .rx_valid_o     (rx_valid_o),
      .rx_packet_o    (rx_packet_o),
      .rx_credit_i    (rx_credit_i),
      .mailbox_clr_i  (mailbox_clr_i),
      .mailbox_data_o (mailbox_data_o),
      .mailbox_irq_o  (mailbox_irq_o),
      .chipid_o       (chipid_o),
      .elink_active_o (elink_active_o)
   );

   pio_pads u_pio_pads (
      .sys_clk_i   (sys_clk_i),
      .rst_i       (rst_i),
      .ps_gpio_o_i (ps_gpio_o_i),
      .ps_gpio_t_i (ps_gpio_t_i),
      .ps_gpio_i_o (ps_gpio_i_o),
      .gpio_io     (gpio_io),
      .i2c_scl_o_i (i2c_scl_o_i),
      .i2c_scl_t_i (i2c_scl_t_i),
      .i2c_sda_o_i (i2c_sda_o_i),
      .i2c_sda_t_i (i2c_sda_t_i),
      .i2c_scl_i_o (i2c_scl_i_o),
      .i2c_sda_i_o (i2c_sda_i_o),
      .i2c_scl_io  (i2c_scl_io),
      .i2c_sda_io  (i2c_sda_io)
   );

   always_ff @(posedge sys_clk_i) begin
      if (rst_i) begin
         chip_nreset_o <= 1'b0;                 // Chip held in reset
      end else begin
         chip_nreset_o <= 1'b1;
      end
   end

endmodule

// ==== tb_parallella_base.sv ====
`timescale 1ns/1ns
`include "elink_macros.svh"

module tb_parallella_base;

   localparam int LIMIT = 2000;                        // Cycles allowed per wait

   logic               sys_clk_i;
   logic               rst_i;
   logic               tx_valid_i;
   elink_pkg::packet_t tx_packet_i;
   logic               tx_credit_o;
   logic [7:0]         txo_data_o;
   logic               txo_frame_o;
   logic               rxo_credit_o;
   logic               rx_valid_o;
   elink_pkg::packet_t rx_packet_o;
   logic               rx_credit_i;
   logic               mailbox_clr_i;
   logic [63:0]        mailbox_data_o;
   logic               mailbox_irq_o;
   logic [11:0]        chipid_o;
   logic               elink_active_o;
   logic [`NGPIO-1:0]  ps_gpio_o_i;
   logic [`NGPIO-1:0]  ps_gpio_t_i;
   logic [`NGPIO-1:0]  ps_gpio_i_o;
   wire  [`NGPIO-1:0]  gpio_io;
   logic               i2c_scl_o_i;
   logic               i2c_scl_t_i;
   logic               i2c_sda_o_i;
   logic               i2c_sda_t_i;
   logic               i2c_scl_i_o;
   logic               i2c_sda_i_o;
   wire                i2c_scl_io;
   wire                i2c_sda_io;
   logic               chip_nreset_o;

   logic               gpio_drv_en;                    // Board side GPIO driver on
   logic [`NGPIO-1:0]  gpio_drv;
   logic               sda_pull_low;                   // I2C slave holding SDA

   int                 host_credits;                   // Tx credits held by host
   int                 tx_pulses;                      // All tx_credit_o pulses
   int                 link_returns;                   // All rxo_credit_o pulses
   int                 credit_owed;                    // Rx credits still to return
   bit                 auto_credit;                    // Return rx credit per delivery
   bit                 active_seen;
   logic [31:0]        rng;
   elink_pkg::packet_t exp_q[$];                       // Expected at rx_packet_o
   elink_pkg::packet_t rcvd_q[$];                      // Seen at rx_packet_o

   // Pad models with weak pull-ups under everything
   assign (weak0, weak1) gpio_io    = {`NGPIO{1'b1}};
   assign (weak0, weak1) i2c_scl_io = 1'b1;
   assign (weak0, weak1) i2c_sda_io = 1'b1;
   assign gpio_io    = gpio_drv_en ? gpio_drv : {`NGPIO{1'bz}};
   assign i2c_sda_io = sda_pull_low ? 1'b0 : 1'bz;     // Open drain

   parallella_base u_parallella_base (
      .sys_clk_i      (sys_clk_i),
      .rst_i          (rst_i),
      .tx_valid_i     (tx_valid_i),
      .tx_packet_i    (tx_packet_i),
      .tx_credit_o    (tx_credit_o),
      .txi_credit_i   (rxo_credit_o),                  // Loopback credit
      .txo_data_o     (txo_data_o),
      .txo_frame_o    (txo_frame_o),
      .rxi_data_i     (txo_data_o),                    // Loopback lane
      .rxi_frame_i    (txo_frame_o),
      .rxo_credit_o   (rxo_credit_o),
      .rx_valid_o     (rx_valid_o),
      .rx_packet_o    (rx_packet_o),
      .rx_credit_i    (rx_credit_i),
      .mailbox_clr_i  (mailbox_clr_i),
      .mailbox_data_o (mailbox_data_o),
      .mailbox_irq_o  (mailbox_irq_o),
      .chipid_o       (chipid_o),
      .elink_active_o (elink_active_o),
      .ps_gpio_o_i    (ps_gpio_o_i),
      .ps_gpio_t_i    (ps_gpio_t_i),
      .ps_gpio_i_o    (ps_gpio_i_o),
      .gpio_io        (gpio_io),
      .i2c_scl_o_i    (i2c_scl_o_i),
      .i2c_scl_t_i    (i2c_scl_t_i),
      .i2c_sda_o_i    (i2c_sda_o_i),
      .i2c_sda_t_i    (i2c_sda_t_i),
      .i2c_scl_i_o    (i2c_scl_i_o),
      .i2c_sda_i_o    (i2c_sda_i_o),
      .i2c_scl_io     (i2c_scl_io),
      .i2c_sda_io     (i2c_sda_io),
      .chip_nreset_o  (chip_nreset_o)
   );

   initial begin
      sys_clk_i = 1'b0;
      forever #50 sys_clk_i = ~sys_clk_i;              // 100 ns period
   end

   task automatic abort(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [127:0] got,
                        input logic [127:0] exp);
      if (got !== exp) begin
         abort($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                         $time, name, got, exp));
      end
   endtask

   // Sample just after the edge and drive the next inputs
   task automatic tick();
      @(posedge sys_clk_i);
      #5;
      if (tx_credit_o) begin
         host_credits++;
         tx_pulses++;
      end
      if (rxo_credit_o) begin
         link_returns++;
      end
      if (rx_valid_o) begin
         rcvd_q.push_back(rx_packet_o);
         if (auto_credit) begin
            credit_owed++;
         end
      end
      if (elink_active_o) begin
         active_seen = 1'b1;
      end
      rx_credit_i = (credit_owed > 0);                 // One credit per cycle
      if (credit_owed > 0) begin
         credit_owed--;
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic elink_pkg::packet_t random_packet();
      elink_pkg::packet_t p;
      logic [127:0]       bits;
      bits = '0;
      for (int i = 0; i < 4; i++) begin
         rng  = xorshift32(rng);
         bits = {bits[95:0], rng};
      end
      p = elink_pkg::packet_t'(bits[`ELINK_PW-1:0]);
      if (p.dstaddr[31:20] == 12'h810) begin
         p.dstaddr[31] = 1'b0;                         // Stay clear of the mailbox
      end
      return p;
   endfunction

   task automatic send_packet(input elink_pkg::packet_t p, input bit to_host);
      int n;
      n = 0;
      while (host_credits == 0) begin
         tick();
         n++;
         if (n > LIMIT) abort("Timeout: the host got no tx credit back");
      end
      tx_valid_i  = 1'b1;
      tx_packet_i = p;
      host_credits--;
      if (to_host) begin
         exp_q.push_back(p);
      end
      tick();
      tx_valid_i = 1'b0;
   endtask

   task automatic wait_rcvd(input int count);
      int n;
      n = 0;
      while (rcvd_q.size() < count) begin
         tick();
         n++;
         if (n > LIMIT) abort("Timeout: too few packets reached the host");
      end
   endtask

   task automatic wait_pulses(input int count);
      int n;
      n = 0;
      while (tx_pulses < count) begin
         tick();
         n++;
         if (n > LIMIT) abort("Timeout: too few tx credit pulses");
      end
   endtask

   task automatic wait_frame_low();
      int n;
      n = 0;
      while (txo_frame_o) begin
         tick();
         n++;
         if (n > LIMIT) abort("Timeout: the link frame never ended");
      end
   endtask

   task automatic wait_irq();
      int n;
      n = 0;
      while (!mailbox_irq_o) begin
         tick();
         n++;
         if (n > LIMIT) abort("Timeout: the mailbox interrupt never rose");
      end
   endtask

   task automatic compare_rcvd();
      check("received count", rcvd_q.size(), exp_q.size());
      while (exp_q.size() > 0) begin
         check("rx_packet_o", rcvd_q.pop_front(), exp_q.pop_front());
      end
   endtask

   task automatic clear_irq();
      mailbox_clr_i = 1'b1;
      tick();
      mailbox_clr_i = 1'b0;
      check("mailbox_irq_o", mailbox_irq_o, 1'b0);     // Cleared on next edge
   endtask

   task automatic test_reset();
      rst_i = 1'b1;
      repeat (4) tick();
      check("chip_nreset_o", chip_nreset_o, 1'b0);
      rst_i = 1'b0;
      tick();
      check("chip_nreset_o", chip_nreset_o, 1'b1);
      check("tx_credit_o", tx_credit_o, 1'b0);
      check("txo_frame_o", txo_frame_o, 1'b0);
      check("rxo_credit_o", rxo_credit_o, 1'b0);
      check("rx_valid_o", rx_valid_o, 1'b0);
      check("mailbox_irq_o", mailbox_irq_o, 1'b0);
      check("elink_active_o", elink_active_o, 1'b0);
      check("chipid_o", chipid_o, 12'h810);
      check("host credits", host_credits, `ELINK_TX_DEPTH);
      check("tx_credit_o pulses", tx_pulses, 0);
   endtask

   task automatic test_single_packet();
      elink_pkg::packet_t wr;
      elink_pkg::packet_t rd;
      int                 pulses0;
      wr                = '0;
      wr.write          = 1'b1;
      wr.datamode       = elink_pkg::DM_WORD;
      wr.dstaddr        = 32'h8080_0010;               // Foreign chip 808
      wr.data           = 32'hcafe_0001;
      rd                = '0;
      rd.datamode       = elink_pkg::DM_WORD;
      rd.ctrlmode       = 5'h03;
      rd.dstaddr        = 32'h8090_0200;
      rd.upper.srcaddr  = 32'h8100_0040;               // Return address
      auto_credit = 1'b1;
      active_seen = 1'b0;
      pulses0     = tx_pulses;
      send_packet(wr, 1'b1);
      send_packet(rd, 1'b1);
      wait_rcvd(2);
      compare_rcvd();
      check("tx_credit_o pulses", tx_pulses - pulses0, 2);
      check("elink_active_o seen", active_seen, 1'b1);
   endtask

   task automatic test_backpressure();
      int pulses0;
      auto_credit = 1'b0;                              // Host holds its rx credits
      pulses0     = tx_pulses;
      for (int i = 0; i < 8; i++) begin
         send_packet(random_packet(), 1'b1);
      end
      // Link stalls once remote slots plus host deliveries are used up
      wait_pulses(pulses0 + `ELINK_RX_DEPTH + `ELINK_HOST_CREDITS);
      wait_frame_low();
      repeat (3) tick();                               // Push and then deliver
      check("delivered while stalled", rcvd_q.size(), `ELINK_HOST_CREDITS);
      check("tx_credit_o pulses", tx_pulses - pulses0,
            `ELINK_RX_DEPTH + `ELINK_HOST_CREDITS);
      credit_owed = credit_owed + `ELINK_HOST_CREDITS;
      auto_credit = 1'b1;
      wait_rcvd(8);
      compare_rcvd();
      check("tx_credit_o pulses", tx_pulses - pulses0, 8);
   endtask

   task automatic test_mailbox();
      elink_pkg::packet_t mb;
      int                 returns0;
      mb               = '0;
      mb.write         = 1'b1;
      mb.datamode      = elink_pkg::DM_DOUBLE;
      mb.dstaddr       = {12'h810, 20'hF0320};
      mb.data          = 32'h1234_5678;
      mb.upper.data_hi = 32'h9abc_def0;
      returns0         = link_returns;
      send_packet(mb, 1'b0);
      wait_irq();
      repeat (3) tick();                               // Room for a stray delivery
      check("rx_valid_o count", rcvd_q.size(), 0);
      check("rxo_credit_o pulses", link_returns - returns0, 1);  // Slot freed at capture
      check("mailbox_data_o", mailbox_data_o, 64'h9abc_def0_1234_5678);
      clear_irq();
      mb.datamode = elink_pkg::DM_WORD;                // Upper word now srcaddr
      mb.data     = 32'h0bad_f00d;
      send_packet(mb, 1'b0);
      wait_irq();
      check("mailbox_data_o", mailbox_data_o, 64'h0000_0000_0bad_f00d);
      clear_irq();
      check("rx_valid_o count", rcvd_q.size(), 0);
      check("rxo_credit_o pulses", link_returns - returns0, 2);
   endtask

   task automatic test_pads();
      logic [`NGPIO-1:0] pat_out;
      logic [`NGPIO-1:0] pat_in;
      pat_out     = 24'ha5c30f;
      pat_in      = 24'h3c5a96;
      ps_gpio_o_i = pat_out;
      ps_gpio_t_i = '0;                                // DUT drives the pads
      repeat (3) tick();
      check("gpio_io", gpio_io, pat_out);
      check("ps_gpio_i_o", ps_gpio_i_o, pat_out);
      ps_gpio_t_i = '1;
      gpio_drv    = pat_in;
      gpio_drv_en = 1'b1;
      tick();
      check("ps_gpio_i_o", ps_gpio_i_o, pat_out);      // Still in sync stages
      tick();
      check("ps_gpio_i_o", ps_gpio_i_o, pat_in);
      gpio_drv_en = 1'b0;
      i2c_scl_o_i = 1'b0;
      i2c_scl_t_i = 1'b0;                              // Pull SCL low
      repeat (2) tick();
      check("i2c_scl_io", i2c_scl_io, 1'b0);
      check("i2c_scl_i_o", i2c_scl_i_o, 1'b0);
      i2c_scl_t_i = 1'b1;
      repeat (2) tick();
      check("i2c_scl_io", i2c_scl_io, 1'b1);           // Pull-up only
      check("i2c_scl_i_o", i2c_scl_i_o, 1'b1);
      sda_pull_low = 1'b1;
      repeat (2) tick();
      check("i2c_sda_i_o", i2c_sda_i_o, 1'b0);
      sda_pull_low = 1'b0;
      repeat (2) tick();
      check("i2c_sda_i_o", i2c_sda_i_o, 1'b1);
      i2c_sda_o_i = 1'b0;
      i2c_sda_t_i = 1'b0;                              // DUT pulls SDA low
      repeat (2) tick();
      check("i2c_sda_io", i2c_sda_io, 1'b0);
      check("i2c_sda_i_o", i2c_sda_i_o, 1'b0);
      i2c_sda_o_i = 1'b1;                              // High level only floats
      repeat (2) tick();
      check("i2c_sda_io", i2c_sda_io, 1'b1);
      check("i2c_sda_i_o", i2c_sda_i_o, 1'b1);
   endtask

   initial begin
      rst_i         = 1'b1;
      tx_valid_i    = 1'b0;
      tx_packet_i   = '0;
      rx_credit_i   = 1'b0;
      mailbox_clr_i = 1'b0;
      ps_gpio_o_i   = '0;
      ps_gpio_t_i   = '1;                              // Pads float
      i2c_scl_o_i   = 1'b0;
      i2c_scl_t_i   = 1'b1;
      i2c_sda_o_i   = 1'b0;
      i2c_sda_t_i   = 1'b1;
      gpio_drv_en   = 1'b0;
      gpio_drv      = '0;
      sda_pull_low  = 1'b0;
      host_credits  = `ELINK_TX_DEPTH;
      tx_pulses     = 0;
      link_returns  = 0;
      credit_owed   = 0;
      auto_credit   = 1'b0;
      active_seen   = 1'b0;
      rng           = 32'h5f8a16bd;
      test_reset();
      test_single_packet();
      test_backpressure();
      test_mailbox();
      test_pads();
      $display("sim passed");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+.
elink_pkg.sv
elink_tx.sv
elink_rx.sv
elink.sv
pio_pads.sv
parallella_base.sv
tb_parallella_base.sv

// ==== Bender.yml ====
package:
  name: parallella_base

export_include_dirs:
  - .

sources:
  - elink_pkg.sv
  - elink_tx.sv
  - elink_rx.sv
  - elink.sv
  - pio_pads.sv
  - parallella_base.sv
  - target: test
    files:
      - tb_parallella_base.sv
